// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - design
    files:
      - design/rv_core_pkg.sv
      - design/rv_decoder.sv
      - design/rv_regfile.sv
      - design/rv_alu.sv
      - design/rv_lsu.sv
      - design/rv_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/rv_core_tb.sv

// File: design/rv_alu.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_alu (
   input  rv_core_pkg::rv_alu_op_e op,
   input  rv_core_pkg::rv_word_t   a,
   input  rv_core_pkg::rv_word_t   b,
   input  logic [2:0]              branch_funct3,
   output rv_core_pkg::rv_word_t   result,
   output logic                    cond
);
   import rv_core_pkg::*;

   logic       eq;
   logic       lt;
   logic       ltu;
   logic [4:0] shamt;

   assign eq    = (a == b);
   assign lt    = ($signed(a) < $signed(b));
   assign ltu   = (a < b);
   assign shamt = b[4:0];

   always_comb begin
      case (op)
         ALU_ADD:    result = a + b;
         ALU_SUB:    result = a - b;
         ALU_SLL:    result = a << shamt;
         ALU_SLT:    result = {31'b0, lt};
         ALU_SLTU:   result = {31'b0, ltu};
         ALU_XOR:    result = a ^ b;
         ALU_SRL:    result = a >> shamt;
         ALU_SRA:    result = rv_word_t'($signed(a) >>> shamt);
         ALU_OR:     result = a | b;
         ALU_AND:    result = a & b;
         ALU_PASS_B: result = b;
         default:    result = a + b;
      endcase
   end

   // Branch condition, funct3 encoding
   always_comb begin
      case (branch_funct3)
         3'b000:  cond = eq;
         3'b001:  cond = !eq;
         3'b100:  cond = lt;
         3'b101:  cond = !lt;
         3'b110:  cond = ltu;
         3'b111:  cond = !ltu;
         default: cond = 1'b0;
      endcase
   end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core (
   input  logic                      clk,
   input  logic                      rst_n,
   output logic                      imem_valid,
   output rv_core_pkg::rv_imem_req_t imem_req,
   input  rv_core_pkg::rv_imem_rsp_t imem_rsp,
   output logic                      dmem_valid,
   output rv_core_pkg::rv_dmem_req_t dmem_req,
   input  rv_core_pkg::rv_dmem_rsp_t dmem_rsp,
   output logic                      illegal_instruction
);
   import rv_core_pkg::*;

   typedef enum logic [1:0] {
      ST_FETCH, ST_EXEC, ST_MEM, ST_HALT
   } state_e;

   state_e      state_q;
   rv_word_t    pc_q;
   rv_inst_u    inst_q;
   rv_reg_idx_t load_rd_q;
   logic [1:0]  load_addr_lo_q;
   logic        illegal_q;

   rv_ctrl_t    ctrl;
   rv_word_t    imm;
   rv_reg_idx_t dec_rs1;
   rv_reg_idx_t dec_rs2;
   rv_reg_idx_t dec_rd;
   logic        dec_illegal;

   rv_word_t    rs1_data;
   rv_word_t    rs2_data;
   rv_word_t    alu_a;
   rv_word_t    alu_b;
   rv_word_t    alu_result;
   logic        alu_cond;
   rv_word_t    load_data;

   rv_word_t    pc_plus4;
   rv_word_t    pc_target;
   rv_word_t    next_pc;
   rv_word_t    wb_data;
   rv_reg_idx_t wb_rd;
   logic        wb_write;
   logic        mem_access;

   rv_decoder rv_decoder_i (
      .inst    (inst_q),
      .ctrl    (ctrl),
      .imm     (imm),
      .rs1     (dec_rs1),
      .rs2     (dec_rs2),
      .rd      (dec_rd),
      .illegal (dec_illegal)
   );

   rv_regfile rv_regfile_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (dec_rs1),
      .rs2      (dec_rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .rd       (wb_rd),
      .rd_data  (wb_data),
      .rd_write (wb_write)
   );

   // Operand selection
   assign alu_a = ctrl.a_pc ? pc_q : rs1_data;
   assign alu_b = ctrl.b_imm ? imm : rs2_data;

   rv_alu rv_alu_i (
      .op            (ctrl.alu_op),
      .a             (alu_a),
      .b             (alu_b),
      .branch_funct3 (ctrl.branch_funct3),
      .result        (alu_result),
      .cond          (alu_cond)
   );

   rv_lsu rv_lsu_i (
      .ctrl         (ctrl),
      .addr         (alu_result),
      .store_data   (rs2_data),
      .load_addr_lo (load_addr_lo_q),
      .rdata        (dmem_rsp.rdata),
      .dmem_req     (dmem_req),
      .load_data    (load_data)
   );

   // ============================================================
   // Next PC and write-back
   // ============================================================

   assign pc_plus4   = pc_q + `RV_INST_BYTES;
   assign pc_target  = pc_q + imm;
   assign mem_access = ctrl.load || ctrl.store;

   always_comb begin
      if (ctrl.jalr) begin
         next_pc = {alu_result[31:1], 1'b0};
      end else if (ctrl.jal || (ctrl.branch && alu_cond)) begin
         next_pc = pc_target;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_comb begin
      case (ctrl.wb_src)
         WB_MEM:  wb_data = load_data;
         WB_PC4:  wb_data = pc_plus4;
         default: wb_data = alu_result;
      endcase
   end

   // Non-memory ops retire in execute, loads when the data arrives
   assign wb_rd    = (state_q == ST_MEM) ? load_rd_q : dec_rd;
   assign wb_write = (state_q == ST_EXEC && ctrl.reg_write && !dec_illegal && !mem_access) ||
                     (state_q == ST_MEM && dmem_rsp.ready && ctrl.load && ctrl.reg_write);

   // ============================================================
   // Sequencer
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= ST_FETCH;
         pc_q      <= `RV_RESET_PC;
         illegal_q <= 1'b0;
      end else begin
         case (state_q)
            ST_FETCH: begin
               if (imem_rsp.ready) begin
                  state_q <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               if (dec_illegal) begin
                  state_q   <= ST_HALT;
                  illegal_q <= 1'b1;
               end else if (mem_access) begin
                  state_q <= ST_MEM;
               end else begin
                  state_q <= ST_FETCH;
                  pc_q    <= next_pc;
               end
            end
            ST_MEM: begin
               if (dmem_rsp.ready) begin
                  state_q <= ST_FETCH;
                  pc_q    <= next_pc;
               end
            end
            default: begin
               // Halted until reset
               state_q <= ST_HALT;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == ST_FETCH && imem_rsp.ready) begin
         inst_q <= rv_inst_u'(imem_rsp.rdata);
      end
      if (state_q == ST_EXEC) begin
         load_rd_q      <= dec_rd;
         load_addr_lo_q <= alu_result[1:0];
      end
   end

   assign imem_valid          = (state_q == ST_FETCH);
   assign imem_req.addr       = pc_q;
   assign dmem_valid          = (state_q == ST_MEM);
   assign illegal_instruction = illegal_q;

endmodule

// File: design/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// ============================================================
// Core dimensions
// ============================================================

`define RV_XLEN        32
`define RV_NUM_REGS    32

// First fetch address after reset
`define RV_RESET_PC    32'h0000_0000

// Only 32-bit instructions, no compressed set
`define RV_INST_BYTES  32'd4

// ============================================================
// RV32I major opcodes
// ============================================================

`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011

`endif

// File: design/rv_core_pkg.sv
`include "rv_core_consts.svh"

package rv_core_pkg;

   typedef logic [`RV_XLEN-1:0] rv_word_t;
   typedef logic [4:0]          rv_reg_idx_t;

   // ============================================================
   // Instruction formats
   // ============================================================

   typedef struct packed {
      logic [6:0]  funct7;
      rv_reg_idx_t rs2;
      rv_reg_idx_t rs1;
      logic [2:0]  funct3;
      rv_reg_idx_t rd;
      logic [6:0]  opcode;
   } rv_r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      rv_reg_idx_t rs1;
      logic [2:0]  funct3;
      rv_reg_idx_t rd;
      logic [6:0]  opcode;
   } rv_i_fmt_t;

   typedef struct packed {
      logic [6:0]  imm_hi;
      rv_reg_idx_t rs2;
      rv_reg_idx_t rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
   } rv_s_fmt_t;

   typedef struct packed {
      logic        imm_12;
      logic [5:0]  imm_10_5;
      rv_reg_idx_t rs2;
      rv_reg_idx_t rs1;
      logic [2:0]  funct3;
      logic [3:0]  imm_4_1;
      logic        imm_11;
      logic [6:0]  opcode;
   } rv_b_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      rv_reg_idx_t rd;
      logic [6:0]  opcode;
   } rv_u_fmt_t;

   typedef struct packed {
      logic        imm_20;
      logic [9:0]  imm_10_1;
      logic        imm_11;
      logic [7:0]  imm_19_12;
      rv_reg_idx_t rd;
      logic [6:0]  opcode;
   } rv_j_fmt_t;

   // One fetched word, seen through every format
   typedef union packed {
      rv_r_fmt_t r;
      rv_i_fmt_t i;
      rv_s_fmt_t s;
      rv_b_fmt_t b;
      rv_u_fmt_t u;
      rv_j_fmt_t j;
   } rv_inst_u;

   // ============================================================
   // Control encodings
   // ============================================================

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
   } rv_alu_op_e;

   // Same values as the load/store funct3 field
   typedef enum logic [2:0] {
      MEM_B  = 3'b000,
      MEM_H  = 3'b001,
      MEM_W  = 3'b010,
      MEM_BU = 3'b100,
      MEM_HU = 3'b101
   } rv_mem_size_e;

   typedef enum logic [1:0] {
      WB_ALU, WB_MEM, WB_PC4
   } rv_wb_src_e;

   typedef struct packed {
      rv_alu_op_e   alu_op;
      logic         a_pc;
      logic         b_imm;
      rv_wb_src_e   wb_src;
      logic         reg_write;
      logic         load;
      logic         store;
      logic         branch;
      logic         jal;
      logic         jalr;
      rv_mem_size_e mem_size;
      logic [2:0]   branch_funct3;
   } rv_ctrl_t;

   // ============================================================
   // Bus payloads
   // ============================================================

   typedef struct packed {
      rv_word_t addr;
   } rv_imem_req_t;

   typedef struct packed {
      logic     ready;
      rv_word_t rdata;
   } rv_imem_rsp_t;

   typedef struct packed {
      rv_word_t   addr;
      rv_word_t   wdata;
      logic [3:0] be;
      logic       write;
   } rv_dmem_req_t;

   typedef struct packed {
      logic     ready;
      rv_word_t rdata;
   } rv_dmem_rsp_t;

endpackage

// File: design/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_decoder (
   input  rv_core_pkg::rv_inst_u    inst,
   output rv_core_pkg::rv_ctrl_t    ctrl,
   output rv_core_pkg::rv_word_t    imm,
   output rv_core_pkg::rv_reg_idx_t rs1,
   output rv_core_pkg::rv_reg_idx_t rs2,
   output rv_core_pkg::rv_reg_idx_t rd,
   output logic                     illegal
);
   import rv_core_pkg::*;

   rv_word_t imm_i;
   rv_word_t imm_s;
   rv_word_t imm_b;
   rv_word_t imm_u;
   rv_word_t imm_j;
   logic     funct7_zero;
   logic     funct7_alt;

   assign rs1 = inst.r.rs1;
   assign rs2 = inst.r.rs2;
   assign rd  = inst.r.rd;

   // Sign-extended immediates for each format
   assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
   assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
   assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                   inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
   assign imm_u = {inst.u.imm, 12'b0};
   assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                   inst.j.imm_11, inst.j.imm_10_1, 1'b0};

   assign funct7_zero = (inst.r.funct7 == 7'b0000000);
   assign funct7_alt  = (inst.r.funct7 == 7'b0100000);

   always_comb begin
      ctrl               = '0;
      ctrl.alu_op        = ALU_ADD;
      ctrl.wb_src        = WB_ALU;
      ctrl.mem_size      = rv_mem_size_e'(inst.i.funct3);
      ctrl.branch_funct3 = inst.b.funct3;
      imm                = imm_i;
      illegal            = 1'b0;

      case (inst.r.opcode)
         `RV_OP_LUI: begin
            ctrl.alu_op    = ALU_PASS_B;
            ctrl.b_imm     = 1'b1;
            ctrl.reg_write = 1'b1;
            imm            = imm_u;
         end
         `RV_OP_AUIPC: begin
            ctrl.a_pc      = 1'b1;
            ctrl.b_imm     = 1'b1;
            ctrl.reg_write = 1'b1;
            imm            = imm_u;
         end
         `RV_OP_JAL: begin
            ctrl.jal       = 1'b1;
            ctrl.wb_src    = WB_PC4;
            ctrl.reg_write = 1'b1;
            imm            = imm_j;
         end
         `RV_OP_JALR: begin
            ctrl.jalr      = 1'b1;
            ctrl.b_imm     = 1'b1;
            ctrl.wb_src    = WB_PC4;
            ctrl.reg_write = 1'b1;
            illegal        = (inst.i.funct3 != 3'b000);
         end
         `RV_OP_BRANCH: begin
            // Comparison is done by the ALU on rs1 and rs2
            ctrl.branch = 1'b1;
            imm         = imm_b;
            illegal     = (inst.b.funct3[2:1] == 2'b01);
         end
         `RV_OP_LOAD: begin
            ctrl.load      = 1'b1;
            ctrl.b_imm     = 1'b1;
            ctrl.wb_src    = WB_MEM;
            ctrl.reg_write = 1'b1;
            illegal        = (inst.i.funct3 == 3'b011) || (inst.i.funct3[2:1] == 2'b11);
         end
         `RV_OP_STORE: begin
            ctrl.store = 1'b1;
            ctrl.b_imm = 1'b1;
            imm        = imm_s;
            illegal    = (inst.s.funct3[2] || inst.s.funct3 == 3'b011);
         end
         `RV_OP_IMM, `RV_OP_REG: begin
            ctrl.b_imm     = (inst.r.opcode == `RV_OP_IMM);
            ctrl.reg_write = 1'b1;
            case (inst.r.funct3)
               3'b000: ctrl.alu_op = (ctrl.b_imm || !funct7_alt) ? ALU_ADD : ALU_SUB;
               3'b001: ctrl.alu_op = ALU_SLL;
               3'b010: ctrl.alu_op = ALU_SLT;
               3'b011: ctrl.alu_op = ALU_SLTU;
               3'b100: ctrl.alu_op = ALU_XOR;
               3'b101: ctrl.alu_op = funct7_alt ? ALU_SRA : ALU_SRL;
               3'b110: ctrl.alu_op = ALU_OR;
               default: ctrl.alu_op = ALU_AND;
            endcase
            // Immediate shifts reuse funct7, register ops check it everywhere
            if (ctrl.b_imm) begin
               illegal = (inst.r.funct3 == 3'b001 && !funct7_zero) ||
                         (inst.r.funct3 == 3'b101 && !funct7_zero && !funct7_alt);
            end else begin
               illegal = !funct7_zero &&
                         !(funct7_alt && (inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101));
            end
         end
         default: begin
            // Includes the all-zero word
            illegal = 1'b1;
         end
      endcase
   end

endmodule

// File: design/rv_lsu.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_lsu (
   input  rv_core_pkg::rv_ctrl_t     ctrl,
   input  rv_core_pkg::rv_word_t     addr,
   input  rv_core_pkg::rv_word_t     store_data,
   input  logic [1:0]                load_addr_lo,
   input  rv_core_pkg::rv_word_t     rdata,
   output rv_core_pkg::rv_dmem_req_t dmem_req,
   output rv_core_pkg::rv_word_t     load_data
);
   import rv_core_pkg::*;

   logic [3:0] be;
   rv_word_t   wdata_shifted;
   rv_word_t   wdata;
   rv_word_t   rdata_shifted;

   // ============================================================
   // Store lane placement
   // ============================================================

   always_comb begin
      case (ctrl.mem_size)
         MEM_B, MEM_BU: begin
            be            = 4'b0001 << addr[1:0];
            wdata_shifted = store_data << {addr[1:0], 3'b000};
         end
         MEM_H, MEM_HU: begin
            be            = 4'b0011 << {addr[1], 1'b0};
            wdata_shifted = store_data << {addr[1], 4'b0000};
         end
         default: begin
            be            = 4'b1111;
            wdata_shifted = store_data;
         end
      endcase
   end

   // Unused lanes go out as zero, and loads carry no write data
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         wdata[i*8 +: 8] = (ctrl.store && be[i]) ? wdata_shifted[i*8 +: 8] : 8'h00;
      end
   end

   assign dmem_req.addr  = addr;
   assign dmem_req.wdata = wdata;
   assign dmem_req.be    = be;
   assign dmem_req.write = ctrl.store;

   // ============================================================
   // Load extraction
   // ============================================================

   assign rdata_shifted = rdata >> {load_addr_lo, 3'b000};

   always_comb begin
      case (ctrl.mem_size)
         MEM_B:   load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
         MEM_BU:  load_data = {24'b0, rdata_shifted[7:0]};
         MEM_H:   load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
         MEM_HU:  load_data = {16'b0, rdata_shifted[15:0]};
         default: load_data = rdata;
      endcase
   end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_regfile (
   input  logic                     clk,
   input  logic                     rst_n,
   input  rv_core_pkg::rv_reg_idx_t rs1,
   input  rv_core_pkg::rv_reg_idx_t rs2,
   output rv_core_pkg::rv_word_t    rs1_data,
   output rv_core_pkg::rv_word_t    rs2_data,
   input  rv_core_pkg::rv_reg_idx_t rd,
   input  rv_core_pkg::rv_word_t    rd_data,
   input  logic                     rd_write
);
   import rv_core_pkg::*;

   rv_word_t regs [`RV_NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_write && rd != '0) begin
         regs[rd] <= rd_data;
      end
   end

   // x0 reads as zero whatever the array holds
   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rv_core.f
+incdir+design
design/rv_core_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_core.sv
verification/rv_core_tb.sv

// File: verification/program.hex
// One RV32I instruction word per line, in hex, from address 0 upwards
// The last word is all zero and must halt the core
123450B7
67808093
10000113
00112023
001102A3
00111523
00710183
00215203
404182B3
4041D313
003233B3
00001417
00512823
00612A23
00711B23
00108463
00112023
00001463
008004EF
00012023
05D00593
00058567
00012023
00912C23
00A12E23
00810FA3
01611603
01F14683
02C11123
02D100A3
02812223
00000000

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core_tb;
   import rv_core_pkg::*;

   localparam int RESET_CYCLES = 10;
   localparam int PROG_WORDS   = 32;
   localparam int MAX_WAIT     = 3;
   // Worst-case cycles for one instruction with both bus models answering a cycle late
   localparam int INST_CYCLES  = 2 + MAX_WAIT + 1 + 1 + MAX_WAIT + 1;
   localparam int STEP_LIMIT   = 1000;

   typedef struct packed {
      logic         mem;
      rv_dmem_req_t req;
      rv_word_t     rdata;
   } ref_txn_t;

   logic         clk;
   logic         rst_n;
   logic         imem_valid;
   rv_imem_req_t imem_req;
   rv_imem_rsp_t imem_rsp;
   logic         dmem_valid;
   rv_dmem_req_t dmem_req;
   rv_dmem_rsp_t dmem_rsp;
   logic         illegal_instruction;

   rv_word_t     code_mem [64];
   rv_word_t     data_mem [128];
   rv_word_t     ref_dmem [128];
   rv_word_t     ref_regs [`RV_NUM_REGS];
   rv_word_t     ref_pc;
   logic         ref_halted;
   logic         halt_seen;
   logic [31:0]  lfsr;
   int           error_count;
   int           check_count;
   int           xfer_count;

   rv_core rv_core_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .imem_valid          (imem_valid),
      .imem_req            (imem_req),
      .imem_rsp            (imem_rsp),
      .dmem_valid          (dmem_valid),
      .dmem_req            (dmem_req),
      .dmem_rsp            (dmem_rsp),
      .illegal_instruction (illegal_instruction)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ============================================================
   // Checks and random wait states
   // ============================================================

   task automatic check_dmem_req(input rv_dmem_req_t got, input rv_dmem_req_t exp,
                                 input string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error at %0t: %s got addr %h wdata %h be %b write %b,", $time, what,
                  got.addr, got.wdata, got.be, got.write);
         $display("   expected addr %h wdata %h be %b write %b",
                  exp.addr, exp.wdata, exp.be, exp.write);
      end
   endtask

   task automatic check_word(input rv_word_t got, input rv_word_t exp, input string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_wait(output int n);
      logic [1:0] w;
      w = '0;
      for (int k = 0; k < 2; k++) begin
         lfsr = lfsr_next(lfsr);
         w    = {w[0], lfsr[0]};
      end
      n = w;
   endtask

   // ============================================================
   // Reference instruction model
   // ============================================================

   function automatic ref_txn_t ref_step();
      ref_txn_t   t;
      rv_word_t   ins;
      rv_word_t   a;
      rv_word_t   b;
      rv_word_t   imm_i;
      rv_word_t   imm_s;
      rv_word_t   res;
      rv_word_t   addr;
      rv_word_t   word;
      rv_word_t   next;
      logic [6:0] op;
      logic [2:0] f3;
      logic [4:0] rd;
      logic       wr;
      logic       take;
      t     = '0;
      ins   = code_mem[ref_pc[7:2]];
      op    = ins[6:0];
      f3    = ins[14:12];
      rd    = ins[11:7];
      a     = (ins[19:15] == 0) ? '0 : ref_regs[ins[19:15]];
      b     = (ins[24:20] == 0) ? '0 : ref_regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      next  = ref_pc + 4;
      wr    = 1'b1;
      res   = '0;
      case (op)
         7'b0110111: res = {ins[31:12], 12'b0};
         7'b0010111: res = ref_pc + {ins[31:12], 12'b0};
         7'b1101111: begin
            res  = ref_pc + 4;
            next = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         7'b1100111: begin
            res  = ref_pc + 4;
            next = (a + imm_i) & ~32'h1;
         end
         7'b1100011: begin
            wr = 1'b0;
            case (f3)
               3'b000:  take = (a == b);
               3'b001:  take = (a != b);
               3'b100:  take = ($signed(a) < $signed(b));
               3'b101:  take = ($signed(a) >= $signed(b));
               3'b110:  take = (a < b);
               default: take = (a >= b);
            endcase
            if (take) begin
               next = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         7'b0000011: begin
            addr    = a + imm_i;
            word    = ref_dmem[addr[8:2]];
            t.mem   = 1'b1;
            t.rdata = word;
            word    = word >> (addr[1:0] * 8);
            case (f3)
               3'b000:  res = {{24{word[7]}}, word[7:0]};
               3'b100:  res = {24'b0, word[7:0]};
               3'b001:  res = {{16{word[15]}}, word[15:0]};
               3'b101:  res = {16'b0, word[15:0]};
               default: res = word;
            endcase
            t.req.addr = addr;
            t.req.be   = (f3[1:0] == 2'b00) ? 4'b0001 << addr[1:0] :
                         (f3[1:0] == 2'b01) ? 4'b0011 << (addr[1] * 2) : 4'b1111;
         end
         7'b0100011: begin
            wr          = 1'b0;
            addr        = a + imm_s;
            t.mem       = 1'b1;
            t.req.addr  = addr;
            t.req.write = 1'b1;
            case (f3)
               3'b000: begin
                  t.req.be    = 4'b0001 << addr[1:0];
                  t.req.wdata = {24'b0, b[7:0]} << (addr[1:0] * 8);
               end
               3'b001: begin
                  t.req.be    = 4'b0011 << (addr[1] * 2);
                  t.req.wdata = {16'b0, b[15:0]} << (addr[1] * 16);
               end
               default: begin
                  t.req.be    = 4'b1111;
                  t.req.wdata = b;
               end
            endcase
            for (int k = 0; k < 4; k++) begin
               if (t.req.be[k]) begin
                  ref_dmem[addr[8:2]][k*8 +: 8] = t.req.wdata[k*8 +: 8];
               end
            end
         end
         7'b0010011, 7'b0110011: begin
            if (op == 7'b0010011) begin
               b = imm_i;
            end
            case (f3)
               3'b000:  res = (op[5] && ins[30]) ? a - b : a + b;
               3'b001:  res = a << b[4:0];
               3'b010:  res = {31'b0, $signed(a) < $signed(b)};
               3'b011:  res = {31'b0, a < b};
               3'b100:  res = a ^ b;
               3'b101:  res = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
               3'b110:  res = a | b;
               default: res = a & b;
            endcase
         end
         default: begin
            // Anything else stops the model where the core halts
            ref_halted = 1'b1;
            return t;
         end
      endcase
      if (wr && rd != 0) begin
         ref_regs[rd] = res;
      end
      ref_pc = next;
      return t;
   endfunction

   // ============================================================
   // Bus models
   // ============================================================

   int           i_wait;
   int           d_wait;
   logic         i_busy;
   logic         d_busy;
   rv_imem_req_t i_seen;
   rv_dmem_req_t d_seen;

   always @(posedge clk) begin
      if (!rst_n) begin
         imem_rsp <= '0;
         dmem_rsp <= '0;
         i_busy = 1'b0;
         d_busy = 1'b0;
      end else begin
         if (imem_rsp.ready) begin
            imem_rsp <= '0;
            i_busy = 1'b0;
         end else if (imem_valid) begin
            if (!i_busy) begin
               i_busy = 1'b1;
               i_seen = imem_req;
               draw_wait(i_wait);
            end else begin
               check_word(imem_req.addr, i_seen.addr, "fetch address while waiting");
            end
            if (i_wait == 0) begin
               imem_rsp.ready <= 1'b1;
               imem_rsp.rdata <= code_mem[imem_req.addr[7:2]];
            end else begin
               i_wait--;
            end
         end

         if (dmem_rsp.ready) begin
            if (dmem_valid && dmem_req.write) begin
               for (int k = 0; k < 4; k++) begin
                  if (dmem_req.be[k]) begin
                     data_mem[dmem_req.addr[8:2]][k*8 +: 8] = dmem_req.wdata[k*8 +: 8];
                  end
               end
            end
            dmem_rsp <= '0;
            d_busy = 1'b0;
         end else if (dmem_valid) begin
            if (!d_busy) begin
               d_busy = 1'b1;
               d_seen = dmem_req;
               draw_wait(d_wait);
            end else begin
               check_dmem_req(dmem_req, d_seen, "data request while waiting");
            end
            if (d_wait == 0) begin
               dmem_rsp.ready <= 1'b1;
               dmem_rsp.rdata <= data_mem[dmem_req.addr[8:2]];
            end else begin
               d_wait--;
            end
         end
      end
   end

   // ============================================================
   // Compare against the reference
   // ============================================================

   always @(posedge clk) begin
      ref_txn_t t;
      int       steps;
      if (rst_n && dmem_valid && dmem_rsp.ready) begin
         steps = 0;
         t     = '0;
         while (!t.mem && !ref_halted && steps < STEP_LIMIT) begin
            t = ref_step();
            steps++;
         end
         if (!t.mem) begin
            error_count++;
            $display("Core made a data transfer at %0t that the reference never reaches",
                     $time);
         end else begin
            xfer_count++;
            check_dmem_req(dmem_req, t.req, "data request");
            if (!t.req.write) begin
               check_word(dmem_rsp.rdata, t.rdata, "load read word");
            end
         end
      end
   end

   // Both buses stay quiet and the flag stays set once halted
   always @(posedge clk) begin
      if (rst_n && illegal_instruction) begin
         halt_seen = 1'b1;
      end
      if (rst_n && halt_seen && (imem_valid || dmem_valid)) begin
         error_count++;
         $display("Bus request seen at %0t after the core halted", $time);
      end
      if (rst_n && halt_seen && !illegal_instruction) begin
         error_count++;
         $display("illegal_instruction dropped at %0t after the core halted", $time);
      end
   end

   initial begin
      #((RESET_CYCLES + 2 * PROG_WORDS * INST_CYCLES + 50) * 20);
      $display("Run did not finish in time, the core seems to hang");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      ref_txn_t t;
      int       pending;
      rst_n       = 1'b0;
      imem_rsp    = '0;
      dmem_rsp    = '0;
      lfsr        = 32'h65b3fa64;
      error_count = 0;
      check_count = 0;
      xfer_count  = 0;
      halt_seen   = 1'b0;
      ref_pc      = `RV_RESET_PC;
      ref_halted  = 1'b0;
      for (int k = 0; k < 64; k++) begin
         code_mem[k] = '0;
      end
      $readmemh("verification/program.hex", code_mem);
      for (int k = 0; k < 128; k++) begin
         data_mem[k] = (k * 32'h9e3779b9) ^ 32'h5a5aa5a5;
         ref_dmem[k] = data_mem[k];
      end
      for (int k = 0; k < `RV_NUM_REGS; k++) begin
         ref_regs[k] = '0;
      end

      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      wait (illegal_instruction);
      repeat (20) @(posedge clk);

      // Whatever the reference still has to transfer was lost by the core
      pending = 0;
      for (int s = 0; s < STEP_LIMIT && !ref_halted; s++) begin
         t = ref_step();
         if (t.mem) begin
            pending++;
         end
      end
      if (pending != 0 || !ref_halted) begin
         error_count++;
         $display("Core halted with %0d data transfers still expected", pending);
      end
      if (xfer_count == 0) begin
         error_count++;
         $display("No data transfer was seen");
      end

      $display("Checks: %0d, transfers: %0d, errors: %0d", check_count, xfer_count,
               error_count);
      if (error_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
